//--- rt_pkg.sv
package rt_pkg;

  // ----------------------------------------------------------
  // widths
  // ----------------------------------------------------------
  localparam int RAY_ID_W  = 9;   // 512 rays in flight
  localparam int COORD_W   = 8;   // one signed vector coordinate
  localparam int COLOR_W   = 16;
  localparam int RAY_COUNT = 2 ** RAY_ID_W;  // ray store entries

  // ----------------------------------------------------------
  // scalar types
  // ----------------------------------------------------------
  typedef logic [RAY_ID_W-1:0] ray_id_t;

  typedef logic signed [COORD_W-1:0] coord_t;

  // x in [2], y in [1], z in [0]
  typedef coord_t [2:0] vec_t;

  typedef logic [COLOR_W-1:0] color_t;

  // ----------------------------------------------------------
  // enums
  // ----------------------------------------------------------

  // who got the store write port last time
  typedef enum logic {
    GRANT_LAUNCH = 1'b0,
    GRANT_BOUNCE = 1'b1
  } grant_e;

  // progress of the fifo head through the calc / refl fork
  typedef enum logic [1:0] {
    FORK_BOTH_PENDING = 2'd0,  // nobody has taken the head yet
    FORK_CALC_DONE    = 2'd1,  // calc took it, refl still owed
    FORK_REFL_DONE    = 2'd2   // refl took it, calc still owed
  } fork_e;

endpackage

//--- ray_store.sv
`timescale 1ns/10ps

module ray_store import rt_pkg::*; #(
  parameter int unsigned LATENCY = 1
) (
  input  logic    clk,
  input  logic    we,
  input  ray_id_t waddr,
  input  vec_t    wdir,
  input  vec_t    wp_int,
  input  ray_id_t raddr,
  output vec_t    rdir,
  output vec_t    rp_int
);

  localparam int ENTRY_W = 2 * $bits(vec_t);  // dir then p_int

  logic [ENTRY_W-1:0] mem [RAY_COUNT];
  ray_id_t            raddr_q;
  logic [ENTRY_W-1:0] rd_pipe [LATENCY];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= {wdir, wp_int};
    end
    raddr_q <= raddr;  // registered read address
  end

  // read after the address register, so a write lands before the next read
  assign rd_pipe[0] = mem[raddr_q];

  // extra output stages for the slower build
  for (genvar i = 1; i < LATENCY; i++) begin : g_out_stage
    always_ff @(posedge clk) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign {rdir, rp_int} = rd_pipe[LATENCY-1];

endmodule

//--- ray_write_arb.sv
`timescale 1ns/10ps

module ray_write_arb import rt_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,

  // launcher
  input  logic    launch_valid,
  output logic    launch_stall,
  input  ray_id_t launch_ray_id,
  input  vec_t    launch_dir,
  input  vec_t    launch_p_int,

  // bounce updater
  input  logic    bounce_valid,
  output logic    bounce_stall,
  input  ray_id_t bounce_ray_id,
  input  vec_t    bounce_dir,
  input  vec_t    bounce_p_int,

  // ray store write side
  output logic    store_we,
  output ray_id_t store_waddr,
  output vec_t    store_wdir,
  output vec_t    store_wp_int
);

  grant_e last_grant;
  logic   tie;
  logic   launch_win;

  // ----------------------------------------------------------
  // grant decision
  // ----------------------------------------------------------
  assign tie = launch_valid & bounce_valid;

  // launch wins alone, or on a tie when bounce went last
  assign launch_win = launch_valid & (~bounce_valid | (last_grant == GRANT_BOUNCE));

  assign launch_stall = tie & ~launch_win;
  assign bounce_stall = tie & launch_win;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_grant <= GRANT_BOUNCE;  // first tie goes to launch
    end else if (store_we) begin
      last_grant <= launch_win ? GRANT_LAUNCH : GRANT_BOUNCE;
    end
  end

  // ----------------------------------------------------------
  // write port mux, no added latency
  // ----------------------------------------------------------
  assign store_we     = launch_valid | bounce_valid;
  assign store_waddr  = launch_win ? launch_ray_id : bounce_ray_id;
  assign store_wdir   = launch_win ? launch_dir    : bounce_dir;
  assign store_wp_int = launch_win ? launch_p_int  : bounce_p_int;

endmodule

//--- hit_delay_pipe.sv
`timescale 1ns/10ps

module hit_delay_pipe import rt_pkg::*; #(
  parameter int unsigned DEPTH = 1
) (
  input  logic    clk,
  input  logic    rst_n,

  input  logic    in_valid,
  input  ray_id_t in_ray_id,
  input  vec_t    in_normal,
  input  color_t  in_color,
  input  logic    in_is_miss,
  input  logic    in_is_shadow,
  input  logic    in_is_last,

  output logic    out_valid,
  output ray_id_t out_ray_id,
  output vec_t    out_normal,
  output color_t  out_color,
  output logic    out_is_miss,
  output logic    out_is_shadow,
  output logic    out_is_last,

  output logic [$clog2(DEPTH+1)-1:0] in_flight
);

  localparam int REC_W = $bits(ray_id_t) + $bits(vec_t) + $bits(color_t) + 3;
  localparam int CNT_W = $clog2(DEPTH+1);

  logic [DEPTH-1:0] valid_q;
  logic [REC_W-1:0] data_q [DEPTH];

  // valid bits, cleared by reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= in_valid;
      for (int i = 1; i < DEPTH; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // payload shifts every cycle, never stalls
  always_ff @(posedge clk) begin
    data_q[0] <= {in_ray_id, in_normal, in_color, in_is_miss, in_is_shadow, in_is_last};
    for (int i = 1; i < DEPTH; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  assign out_valid = valid_q[DEPTH-1];
  assign {out_ray_id, out_normal, out_color, out_is_miss, out_is_shadow, out_is_last} =
    data_q[DEPTH-1];

  // records that still have to land in the fifo
  always_comb begin
    in_flight = '0;
    for (int i = 0; i < DEPTH; i++) begin
      in_flight = in_flight + CNT_W'(valid_q[i]);
    end
  end

endmodule

//--- hit_fifo.sv
`timescale 1ns/10ps

module hit_fifo import rt_pkg::*; #(
  parameter int unsigned DEPTH = 4
) (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    we,
  input  logic    re,

  input  ray_id_t in_ray_id,
  input  vec_t    in_dir,
  input  vec_t    in_p_int,
  input  vec_t    in_normal,
  input  color_t  in_color,
  input  logic    in_is_miss,
  input  logic    in_is_shadow,
  input  logic    in_is_last,

  output ray_id_t out_ray_id,
  output vec_t    out_dir,
  output vec_t    out_p_int,
  output vec_t    out_normal,
  output color_t  out_color,
  output logic    out_is_miss,
  output logic    out_is_shadow,
  output logic    out_is_last,

  output logic    empty,
  output logic [$clog2(DEPTH+1)-1:0] free_slots
);

  localparam int ENTRY_W = $bits(ray_id_t) + 3 * $bits(vec_t) + $bits(color_t) + 3;
  localparam int PTR_W   = $clog2(DEPTH);
  localparam int CNT_W   = $clog2(DEPTH+1);

  logic [ENTRY_W-1:0] mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               do_rd;

  assign do_rd = re & ~empty;  // a read on empty is ignored

  // ----------------------------------------------------------
  // pointers and occupancy
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (we) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      if (we && !do_rd) begin
        count <= count + 1'b1;
      end else if (!we && do_rd) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_ptr] <= {in_ray_id, in_dir, in_p_int, in_normal, in_color,
                      in_is_miss, in_is_shadow, in_is_last};
    end
  end

  assign {out_ray_id, out_dir, out_p_int, out_normal, out_color,
          out_is_miss, out_is_shadow, out_is_last} = mem[rd_ptr];  // head, show-ahead

  assign empty      = (count == '0);
  assign free_slots = CNT_W'(DEPTH) - count;

endmodule

//--- dirpint.sv
`timescale 1ns/10ps

module dirpint import rt_pkg::*; #(
  parameter int unsigned STORE_LATENCY = 1,
  parameter int unsigned FIFO_DEPTH    = 4
) (
  input  logic    clk,
  input  logic    rst_n,

  // hit records from the shading cache
  input  logic    hit_valid,
  output logic    hit_stall,
  input  ray_id_t hit_ray_id,
  input  vec_t    hit_normal,
  input  color_t  hit_color,
  input  logic    hit_is_miss,
  input  logic    hit_is_shadow,
  input  logic    hit_is_last,

  // ray store read side
  output ray_id_t store_raddr,
  input  vec_t    store_rdir,
  input  vec_t    store_rp_int,

  // to direct lighting
  output logic    calc_valid,
  input  logic    calc_stall,
  output ray_id_t calc_ray_id,
  output vec_t    calc_dir,
  output vec_t    calc_p_int,
  output vec_t    calc_normal,
  output color_t  calc_color,
  output logic    calc_is_miss,
  output logic    calc_is_shadow,
  output logic    calc_is_last,

  // to the reflection sender
  output logic    refl_valid,
  input  logic    refl_stall,
  output ray_id_t refl_ray_id,
  output vec_t    refl_dir,
  output vec_t    refl_p_int,
  output vec_t    refl_normal
);

  localparam int FLIGHT_W = $clog2(STORE_LATENCY+1);
  localparam int FREE_W   = $clog2(FIFO_DEPTH+1);

  logic                pipe_valid;
  ray_id_t             pipe_ray_id;
  vec_t                pipe_normal;
  color_t              pipe_color;
  logic                pipe_is_miss;
  logic                pipe_is_shadow;
  logic                pipe_is_last;
  logic [FLIGHT_W-1:0] in_flight;

  logic                fifo_empty;
  logic [FREE_W-1:0]   free_slots;
  logic                fifo_re;

  fork_e               fork_q;
  fork_e               fork_d;
  logic                head_to_refl;
  logic                calc_take;
  logic                refl_take;
  logic                calc_done;
  logic                refl_done;

  // ----------------------------------------------------------
  // intake and store read
  // ----------------------------------------------------------
  assign store_raddr = hit_ray_id;  // read every cycle, only accepted ones matter

  // hold off unless every record already in flight still has a slot
  assign hit_stall = (free_slots <= in_flight);

  hit_delay_pipe #(.DEPTH(STORE_LATENCY)) i_hit_delay_pipe (
    .clk,
    .rst_n,
    .in_valid      (hit_valid & ~hit_stall),
    .in_ray_id     (hit_ray_id),
    .in_normal     (hit_normal),
    .in_color      (hit_color),
    .in_is_miss    (hit_is_miss),
    .in_is_shadow  (hit_is_shadow),
    .in_is_last    (hit_is_last),
    .out_valid     (pipe_valid),
    .out_ray_id    (pipe_ray_id),
    .out_normal    (pipe_normal),
    .out_color     (pipe_color),
    .out_is_miss   (pipe_is_miss),
    .out_is_shadow (pipe_is_shadow),
    .out_is_last   (pipe_is_last),
    .in_flight     (in_flight)
  );

  // ----------------------------------------------------------
  // merge into the fifo
  // ----------------------------------------------------------
  hit_fifo #(.DEPTH(FIFO_DEPTH)) i_hit_fifo (
    .clk,
    .rst_n,
    .we            (pipe_valid),  // store data lines up with the pipe exit
    .re            (fifo_re),
    .in_ray_id     (pipe_ray_id),
    .in_dir        (store_rdir),
    .in_p_int      (store_rp_int),
    .in_normal     (pipe_normal),
    .in_color      (pipe_color),
    .in_is_miss    (pipe_is_miss),
    .in_is_shadow  (pipe_is_shadow),
    .in_is_last    (pipe_is_last),
    .out_ray_id    (calc_ray_id),
    .out_dir       (calc_dir),
    .out_p_int     (calc_p_int),
    .out_normal    (calc_normal),
    .out_color     (calc_color),
    .out_is_miss   (calc_is_miss),
    .out_is_shadow (calc_is_shadow),
    .out_is_last   (calc_is_last),
    .empty         (fifo_empty),
    .free_slots    (free_slots)
  );

  // ----------------------------------------------------------
  // output fork
  // ----------------------------------------------------------
  // reflect only a real hit that is not the last bounce
  assign head_to_refl = ~(calc_is_miss | calc_is_shadow | calc_is_last);

  assign calc_valid = ~fifo_empty & (fork_q != FORK_CALC_DONE);
  assign refl_valid = ~fifo_empty & head_to_refl & (fork_q != FORK_REFL_DONE);

  assign calc_take = calc_valid & ~calc_stall;
  assign refl_take = refl_valid & ~refl_stall;

  assign calc_done = calc_take | (fork_q == FORK_CALC_DONE);
  assign refl_done = ~head_to_refl | refl_take | (fork_q == FORK_REFL_DONE);

  assign fifo_re = ~fifo_empty & calc_done & refl_done;  // both sides served

  always_comb begin
    fork_d = fork_q;
    if (fifo_re) begin
      fork_d = FORK_BOTH_PENDING;
    end else if (calc_take) begin
      fork_d = FORK_CALC_DONE;   // refl still stalled
    end else if (refl_take) begin
      fork_d = FORK_REFL_DONE;   // calc still stalled
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fork_q <= FORK_BOTH_PENDING;
    end else begin
      fork_q <= fork_d;
    end
  end

  assign refl_ray_id = calc_ray_id;
  assign refl_dir    = calc_dir;
  assign refl_p_int  = calc_p_int;
  assign refl_normal = calc_normal;

endmodule

//--- dirpint_top.sv
`timescale 1ns/10ps

module dirpint_top import rt_pkg::*; #(
  parameter int unsigned STORE_LATENCY = 2,
  parameter int unsigned FIFO_DEPTH    = 4
) (
  input  logic    clk,
  input  logic    rst_n,

  input  logic    launch_valid,
  output logic    launch_stall,
  input  ray_id_t launch_ray_id,
  input  vec_t    launch_dir,
  input  vec_t    launch_p_int,

  input  logic    bounce_valid,
  output logic    bounce_stall,
  input  ray_id_t bounce_ray_id,
  input  vec_t    bounce_dir,
  input  vec_t    bounce_p_int,

  input  logic    hit_valid,
  output logic    hit_stall,
  input  ray_id_t hit_ray_id,
  input  vec_t    hit_normal,
  input  color_t  hit_color,
  input  logic    hit_is_miss,
  input  logic    hit_is_shadow,
  input  logic    hit_is_last,

  output logic    calc_valid,
  input  logic    calc_stall,
  output ray_id_t calc_ray_id,
  output vec_t    calc_dir,
  output vec_t    calc_p_int,
  output vec_t    calc_normal,
  output color_t  calc_color,
  output logic    calc_is_miss,
  output logic    calc_is_shadow,
  output logic    calc_is_last,

  output logic    refl_valid,
  input  logic    refl_stall,
  output ray_id_t refl_ray_id,
  output vec_t    refl_dir,
  output vec_t    refl_p_int,
  output vec_t    refl_normal
);

  // ----------------------------------------------------------
  // store write and read sides
  // ----------------------------------------------------------
  logic    store_we;
  ray_id_t store_waddr;
  vec_t    store_wdir;
  vec_t    store_wp_int;
  ray_id_t store_raddr;
  vec_t    store_rdir;
  vec_t    store_rp_int;

  ray_write_arb i_ray_write_arb (
    .clk,
    .rst_n,
    .launch_valid,
    .launch_stall,
    .launch_ray_id,
    .launch_dir,
    .launch_p_int,
    .bounce_valid,
    .bounce_stall,
    .bounce_ray_id,
    .bounce_dir,
    .bounce_p_int,
    .store_we,
    .store_waddr,
    .store_wdir,
    .store_wp_int
  );

  ray_store #(.LATENCY(STORE_LATENCY)) i_ray_store (
    .clk,
    .we     (store_we),
    .waddr  (store_waddr),
    .wdir   (store_wdir),
    .wp_int (store_wp_int),
    .raddr  (store_raddr),
    .rdir   (store_rdir),
    .rp_int (store_rp_int)
  );

  dirpint #(
    .STORE_LATENCY (STORE_LATENCY),  // must match the store read delay
    .FIFO_DEPTH    (FIFO_DEPTH)
  ) i_dirpint (
    .clk,
    .rst_n,
    .hit_valid,
    .hit_stall,
    .hit_ray_id,
    .hit_normal,
    .hit_color,
    .hit_is_miss,
    .hit_is_shadow,
    .hit_is_last,
    .store_raddr,
    .store_rdir,
    .store_rp_int,
    .calc_valid,
    .calc_stall,
    .calc_ray_id,
    .calc_dir,
    .calc_p_int,
    .calc_normal,
    .calc_color,
    .calc_is_miss,
    .calc_is_shadow,
    .calc_is_last,
    .refl_valid,
    .refl_stall,
    .refl_ray_id,
    .refl_dir,
    .refl_p_int,
    .refl_normal
  );

endmodule

//--- dirpint_tb.sv
`timescale 1ns/10ps

module dirpint_tb import rt_pkg::*; ();

  localparam int   STORE_LATENCY = 2;
  localparam int   FIFO_DEPTH    = 4;
  localparam int   ROWS          = 16;
  localparam int   TIMEOUT       = 200;  // cycles allowed per wait
  localparam logic SEL_LAUNCH    = 1'b0;
  localparam logic SEL_BOUNCE    = 1'b1;

  logic    clk;
  logic    rst_n;
  logic    launch_valid;
  logic    launch_stall;
  ray_id_t launch_ray_id;
  vec_t    launch_dir;
  vec_t    launch_p_int;
  logic    bounce_valid;
  logic    bounce_stall;
  ray_id_t bounce_ray_id;
  vec_t    bounce_dir;
  vec_t    bounce_p_int;
  logic    hit_valid;
  logic    hit_stall;
  ray_id_t hit_ray_id;
  vec_t    hit_normal;
  color_t  hit_color;
  logic    hit_is_miss;
  logic    hit_is_shadow;
  logic    hit_is_last;
  logic    calc_valid;
  logic    calc_stall;
  ray_id_t calc_ray_id;
  vec_t    calc_dir;
  vec_t    calc_p_int;
  vec_t    calc_normal;
  color_t  calc_color;
  logic    calc_is_miss;
  logic    calc_is_shadow;
  logic    calc_is_last;
  logic    refl_valid;
  logic    refl_stall;
  ray_id_t refl_ray_id;
  vec_t    refl_dir;
  vec_t    refl_p_int;
  vec_t    refl_normal;

  // stimulus table with flags as {miss, shadow, last}
  ray_id_t    t_id     [ROWS];
  vec_t       t_dir    [ROWS];
  vec_t       t_pint   [ROWS];
  logic       t_sel    [ROWS];
  vec_t       t_normal [ROWS];
  color_t     t_color  [ROWS];
  logic [2:0] t_flags  [ROWS];

  int     calc_exp[$];  // row indices still owed on calc
  int     refl_exp[$];
  logic   traffic_done;
  integer seed = 32'h2042_93ea;

  dirpint_top #(
    .STORE_LATENCY (STORE_LATENCY),
    .FIFO_DEPTH    (FIFO_DEPTH)
  ) i_dirpint_top (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------------------------------------
  // reporting
  // ------------------------------------------------------------
  task automatic report_fail(input string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      report_fail($sformatf("Mismatch %s expected %0h actual %0h", name, expected, actual));
    end
  endtask

  // ------------------------------------------------------------
  // table
  // ------------------------------------------------------------
  task automatic add_row(input int i, input ray_id_t id, input vec_t dir, input vec_t pint,
                         input logic sel, input vec_t normal, input color_t color,
                         input logic [2:0] flags);
    t_id[i]     = id;
    t_dir[i]    = dir;
    t_pint[i]   = pint;
    t_sel[i]    = sel;
    t_normal[i] = normal;
    t_color[i]  = color;
    t_flags[i]  = flags;
  endtask

  task automatic load_table();
    add_row( 0, 9'h012, 24'h10_20_30, 24'h01_02_03, SEL_LAUNCH, 24'h7f_00_81, 16'hbeef, 3'b000);
    add_row( 1, 9'h1ff, 24'hf0_e0_d0, 24'h7f_7f_7f, SEL_BOUNCE, 24'h00_7f_00, 16'h1234, 3'b000);
    add_row( 2, 9'h0a5, 24'h01_ff_01, 24'h80_80_80, SEL_LAUNCH, 24'h00_00_7f, 16'h0f0f, 3'b100);
    add_row( 3, 9'h15a, 24'h33_44_55, 24'hc0_40_c0, SEL_BOUNCE, 24'h81_81_81, 16'hf00d, 3'b010);
    add_row( 4, 9'h000, 24'h00_00_01, 24'h00_00_00, SEL_LAUNCH, 24'h12_34_56, 16'h0001, 3'b001);
    add_row( 5, 9'h100, 24'h9a_bc_de, 24'h11_22_33, SEL_BOUNCE, 24'h65_43_21, 16'h8000, 3'b000);
    add_row( 6, 9'h0ff, 24'h7f_81_00, 24'h44_55_66, SEL_LAUNCH, 24'hff_ff_ff, 16'hcafe, 3'b000);
    add_row( 7, 9'h033, 24'h05_06_07, 24'h77_88_99, SEL_BOUNCE, 24'h0a_0b_0c, 16'h5a5a, 3'b110);
    add_row( 8, 9'h1c0, 24'h22_11_00, 24'haa_bb_cc, SEL_BOUNCE, 24'h3c_3c_3c, 16'ha5a5, 3'b000);
    add_row( 9, 9'h07e, 24'hde_ad_00, 24'h0d_0e_0f, SEL_LAUNCH, 24'hc3_c3_c3, 16'h7777, 3'b011);
    add_row(10, 9'h181, 24'h60_70_80, 24'h90_a0_b0, SEL_BOUNCE, 24'h01_01_01, 16'h3333, 3'b001);
    add_row(11, 9'h0c3, 24'h2b_3c_4d, 24'h5e_6f_70, SEL_LAUNCH, 24'h80_7f_80, 16'hffff, 3'b000);
    add_row(12, 9'h13c, 24'h11_11_11, 24'h22_22_22, SEL_BOUNCE, 24'h33_33_33, 16'h4444, 3'b100);
    add_row(13, 9'h055, 24'hee_dd_cc, 24'hbb_aa_99, SEL_LAUNCH, 24'h88_77_66, 16'h5555, 3'b111);
    add_row(14, 9'h1aa, 24'h0f_1e_2d, 24'h3c_4b_5a, SEL_BOUNCE, 24'h69_78_87, 16'h9696, 3'b000);
    add_row(15, 9'h001, 24'hf1_f2_f3, 24'he1_e2_e3, SEL_LAUNCH, 24'hd1_d2_d3, 16'h0000, 3'b010);
  endtask

  // ------------------------------------------------------------
  // stream drivers
  // ------------------------------------------------------------
  function automatic logic stall_of(input int port);
    case (port)
      0:       return launch_stall;
      1:       return bounce_stall;
      default: return hit_stall;
    endcase
  endfunction

  // returns on the edge where the transfer happens
  task automatic wait_accept(input int port, input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (stall_of(port)) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        report_fail($sformatf("timed out waiting for %s to be accepted", what));
      end
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic write_rows(input logic sel);
    @(posedge clk);
    for (int i = 0; i < ROWS; i++) begin
      if (t_sel[i] == sel && sel == SEL_LAUNCH) begin
        launch_valid  <= 1'b1;
        launch_ray_id <= t_id[i];
        launch_dir    <= t_dir[i];
        launch_p_int  <= t_pint[i];
        wait_accept(0, $sformatf("launch write of row %0d", i));
      end else if (t_sel[i] == sel) begin
        bounce_valid  <= 1'b1;
        bounce_ray_id <= t_id[i];
        bounce_dir    <= t_dir[i];
        bounce_p_int  <= t_pint[i];
        wait_accept(1, $sformatf("bounce write of row %0d", i));
      end
    end
    if (sel == SEL_LAUNCH) launch_valid <= 1'b0;
    else bounce_valid <= 1'b0;
  endtask

  // launch owns the tie when rows 0 and 1 go out together
  task automatic check_first_tie();
    @(posedge clk);
    @(negedge clk);
    check_value("first tie launch_stall", 0, launch_stall);
    check_value("first tie bounce_stall", 1, bounce_stall);
  endtask

  task automatic set_hit(input int i);
    hit_valid     <= 1'b1;
    hit_ray_id    <= t_id[i];
    hit_normal    <= t_normal[i];
    hit_color     <= t_color[i];
    hit_is_miss   <= t_flags[i][2];
    hit_is_shadow <= t_flags[i][1];
    hit_is_last   <= t_flags[i][0];
  endtask

  task automatic drive_hit(input int i);
    set_hit(i);
    wait_accept(2, $sformatf("hit of row %0d", i));
  endtask

  // ------------------------------------------------------------
  // output side
  // ------------------------------------------------------------
  task automatic latency_check(input int row);
    @(posedge clk);
    set_hit(row);
    @(negedge clk);
    check_value("latency hit_stall", 0, hit_stall);
    @(posedge clk);  // acceptance edge t
    hit_valid <= 1'b0;
    for (int k = 0; k < STORE_LATENCY; k++) begin
      @(negedge clk);
      check_value($sformatf("latency calc_valid after edge t+%0d", k), 0, calc_valid);
    end
    @(negedge clk);
    check_value("latency calc_valid at edge t+latency", 1, calc_valid);
    check_value("latency calc_ray_id", t_id[row], calc_ray_id);
    check_value("latency calc_dir", t_dir[row], calc_dir);
    check_value("latency calc_p_int", t_pint[row], calc_p_int);
  endtask

  task automatic wait_idle(input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (calc_valid || refl_valid) begin
      cycles++;
      if (cycles > TIMEOUT) report_fail($sformatf("timed out waiting for %s", what));
      @(negedge clk);
    end
  endtask

  task automatic collect_calc();
    int idx;
    int cycles;
    while (calc_exp.size() > 0) begin
      cycles = 0;
      @(negedge clk);
      while (!(calc_valid && !calc_stall)) begin
        cycles++;
        if (cycles > TIMEOUT) report_fail("timed out waiting for a record on calc");
        @(negedge clk);
      end
      idx = calc_exp.pop_front();
      check_value($sformatf("calc row %0d ray_id", idx), t_id[idx], calc_ray_id);
      check_value($sformatf("calc row %0d dir", idx), t_dir[idx], calc_dir);
      check_value($sformatf("calc row %0d p_int", idx), t_pint[idx], calc_p_int);
      check_value($sformatf("calc row %0d normal", idx), t_normal[idx], calc_normal);
      check_value($sformatf("calc row %0d color", idx), t_color[idx], calc_color);
      check_value($sformatf("calc row %0d flags", idx), t_flags[idx],
                  {calc_is_miss, calc_is_shadow, calc_is_last});
    end
  endtask

  task automatic collect_refl();
    int idx;
    int cycles;
    while (refl_exp.size() > 0) begin
      cycles = 0;
      @(negedge clk);
      while (!(refl_valid && !refl_stall)) begin
        cycles++;
        if (cycles > TIMEOUT) report_fail("timed out waiting for a record on refl");
        @(negedge clk);
      end
      idx = refl_exp.pop_front();
      check_value($sformatf("refl row %0d ray_id", idx), t_id[idx], refl_ray_id);
      check_value($sformatf("refl row %0d dir", idx), t_dir[idx], refl_dir);
      check_value($sformatf("refl row %0d p_int", idx), t_pint[idx], refl_p_int);
      check_value($sformatf("refl row %0d normal", idx), t_normal[idx], refl_normal);
    end
  endtask

  task automatic drive_random_stalls();
    while (!traffic_done) begin
      @(posedge clk);
      calc_stall <= ($unsigned($random(seed)) % 5) < 2;  // about 40 percent
      refl_stall <= ($unsigned($random(seed)) % 5) < 2;
    end
    calc_stall <= 1'b0;
    refl_stall <= 1'b0;
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    rst_n         = 1'b0;
    launch_valid  = 1'b0;
    launch_ray_id = '0;
    launch_dir    = '0;
    launch_p_int  = '0;
    bounce_valid  = 1'b0;
    bounce_ray_id = '0;
    bounce_dir    = '0;
    bounce_p_int  = '0;
    hit_valid     = 1'b0;
    hit_ray_id    = '0;
    hit_normal    = '0;
    hit_color     = '0;
    hit_is_miss   = 1'b0;
    hit_is_shadow = 1'b0;
    hit_is_last   = 1'b0;
    calc_stall    = 1'b0;
    refl_stall    = 1'b0;
    traffic_done  = 1'b0;
    load_table();

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("reset calc_valid", 0, calc_valid);
    check_value("reset refl_valid", 0, refl_valid);
    check_value("reset hit_stall", 0, hit_stall);
    check_value("reset launch_stall", 0, launch_stall);
    check_value("reset bounce_stall", 0, bounce_stall);

    // both writers compete from the first cycle
    fork
      write_rows(SEL_LAUNCH);
      write_rows(SEL_BOUNCE);
      check_first_tie();
    join

    latency_check(2);
    wait_idle("the latency record to drain");

    for (int i = 0; i < ROWS; i++) begin
      calc_exp.push_back(i);
      if (t_flags[i] == 3'b000) refl_exp.push_back(i);  // routing rule
    end

    fork
      begin
        @(posedge clk);
        for (int i = 0; i < ROWS; i++) begin
          drive_hit(i);
        end
        hit_valid <= 1'b0;
      end
      begin
        fork
          collect_calc();
          collect_refl();
        join
        traffic_done = 1'b1;
      end
      drive_random_stalls();
    join

    // nothing extra may show up afterwards
    repeat (8) begin
      @(negedge clk);
      check_value("idle calc_valid", 0, calc_valid);
      check_value("idle refl_valid", 0, refl_valid);
    end

    $display("** PASS **");
    $finish;
  end

endmodule

//--- files.f
rt_pkg.sv
ray_store.sv
ray_write_arb.sv
hit_delay_pipe.sv
hit_fifo.sv
dirpint.sv
dirpint_top.sv
dirpint_tb.sv
